//--- dcache_mem_top.f
+incdir+include
hw/l1_mem_pkg.sv
hw/cache_sram.sv
hw/read_arbiter.sv
hw/cache_arrays.sv
hw/hit_select.sv
hw/dcache_mem_top.sv
tests/dcache_mem_tb.sv

//--- include/dcache_mem_model.svh
// Reference model of the cache memory block
// mirrors valid bits, tags and lines on every line write, keeps the
// round-robin pointer and predicts the granted port and the response
`ifndef DCACHE_MEM_MODEL_SVH
`define DCACHE_MEM_MODEL_SVH

way_vec_t             m_valid [NUM_SETS];
logic [TAG_WIDTH-1:0] m_tag   [NUM_SETS][NUM_WAYS];
line_t                m_line  [NUM_SETS][NUM_WAYS];
int                   m_ptr;

function automatic void model_reset();
  for (int s = 0; s < NUM_SETS; s++) begin
    m_valid[s] = '0;
  end
  m_ptr = 0;
endfunction

// only enabled ways change, a cleared valid bit invalidates
function automatic void model_line_write(cl_wr_t c);
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (c.way_en[w]) begin
      m_valid[c.idx][w] = c.valid;
      m_tag[c.idx][w]   = c.tag;
      m_line[c.idx][w]  = c.data;
    end
  end
endfunction

// granted port, or -1 when nothing is granted
function automatic int predict_grant(logic [NumPorts-1:0] req,
                                     logic [NumPorts-1:0] prio, logic blk);
  logic [NumPorts-1:0] elig;
  int                  p;
  elig = (|(req & prio)) ? (req & prio) : req;
  if (!blk) begin
    for (int i = 0; i < NumPorts; i++) begin
      p = (m_ptr + i) % NumPorts;
      if (elig[p]) begin
        return p;
      end
    end
  end
  return -1;
endfunction

function automatic rd_rsp_t expected_rsp(rd_req_t r);
  rd_rsp_t e;
  int      word;
  e          = '0;
  e.valid    = 1'b1;
  e.vld_bits = m_valid[r.idx];
  // eight bytes per word
  word       = r.off / 8;
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (m_valid[r.idx][w] && m_tag[r.idx][w] == r.tag) begin
      if (!e.hit) begin
        e.data = m_line[r.idx][w][word];
      end
      e.hit        = 1'b1;
      e.hit_way[w] = 1'b1;
    end
  end
  return e;
endfunction

`endif

//--- tests/dcache_mem_tb.sv
`timescale 1ns/1ps
// Testbench for the L1 data cache memory block
// directed reads, line writes, invalidations and arbitration, then
// random traffic on both ports compared with a reference model
module dcache_mem_tb
  import l1_mem_pkg::*;
();

  localparam int NumPorts = 2;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic    [NumPorts-1:0] rd_req_i;
  logic    [NumPorts-1:0] rd_prio_i;
  rd_req_t [NumPorts-1:0] rd_addr_i;
  logic    [NumPorts-1:0] rd_ack_o;
  logic                   cl_vld_i;
  cl_wr_t                 cl_i;
  rd_rsp_t                rd_rsp_o;

  logic    [31:0]         rng_state   = 32'h9c7d_adf2;
  logic    [NumPorts-1:0] ack_seen    = '0;
  logic                   rsp_pending = 1'b0;
  rd_rsp_t                rsp_exp;

  `include "dcache_mem_model.svh"

  dcache_mem_top #(
    .NumPorts (NumPorts)
  ) dcache_mem_top_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_req_i  (rd_req_i),
    .rd_prio_i (rd_prio_i),
    .rd_addr_i (rd_addr_i),
    .rd_ack_o  (rd_ack_o),
    .cl_vld_i  (cl_vld_i),
    .cl_i      (cl_i),
    .rd_rsp_o  (rd_rsp_o)
  );

  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_rsp(rd_rsp_t got, rd_rsp_t exp);
    if (got !== exp) begin
      $display("MISMATCH rd_rsp_o: got %h, expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_ack(logic [NumPorts-1:0] got, logic [NumPorts-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH rd_ack_o: got %h, expected %h", got, exp);
      abort_run();
    end
  endtask

  // mid-cycle compare, everything is settled at the falling edge
  always @(negedge clk_i) begin : p_compare
    int                  gnt;
    logic [NumPorts-1:0] exp_ack;
    if (rst_ni === 1'b1) begin
      if (!rsp_pending) begin
        rsp_exp = '0;
      end
      check_rsp(rd_rsp_o, rsp_exp);
      gnt     = predict_grant(rd_req_i, rd_prio_i, cl_vld_i);
      exp_ack = '0;
      if (gnt >= 0) begin
        exp_ack[gnt] = 1'b1;
        rsp_exp      = expected_rsp(rd_addr_i[gnt]);
        m_ptr        = (gnt + 1) % NumPorts;
      end
      check_ack(rd_ack_o, exp_ack);
      rsp_pending = (gnt >= 0);
      if (cl_vld_i) begin
        model_line_write(cl_i);
      end
      ack_seen = rd_ack_o;
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic line_t random_line();
    line_t l;
    for (int k = 0; k < WORDS_PER_LINE; k++) begin
      l[k] = {next_rand(), next_rand()};
    end
    return l;
  endfunction

  // one way per write, a tag already valid in the set keeps its way
  function automatic cl_wr_t random_line_write();
    cl_wr_t      c;
    logic [31:0] r;
    int          way;
    r       = next_rand();
    way     = int'(r[1:0]);
    c.idx   = IDX_WIDTH'(r[3:2]);
    c.tag   = TAG_WIDTH'(r[6:4]);
    c.valid = (r[8:7] != 2'd0);
    c.data  = random_line();
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (c.valid && m_valid[c.idx][w] && m_tag[c.idx][w] == c.tag) begin
        way = w;
      end
    end
    c.way_en      = '0;
    c.way_en[way] = 1'b1;
    return c;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic write_line(way_vec_t way_en, logic valid, logic [TAG_WIDTH-1:0] tag,
                            logic [IDX_WIDTH-1:0] idx, line_t data);
    cl_i     = '{way_en: way_en, valid: valid, tag: tag, idx: idx, data: data};
    cl_vld_i = 1'b1;
    next_cycle();
    cl_vld_i = 1'b0;
  endtask

  // hold the request until acked, p_compare checks the response
  task automatic read_word(int port, logic prio, logic [TAG_WIDTH-1:0] tag,
                           logic [IDX_WIDTH-1:0] idx, logic [OFF_WIDTH-1:0] off);
    int   cycles;
    logic acked;
    cycles          = 0;
    acked           = 1'b0;
    rd_req_i[port]  = 1'b1;
    rd_prio_i[port] = prio;
    rd_addr_i[port] = '{tag: tag, idx: idx, off: off};
    while (!acked) begin
      @(negedge clk_i);
      acked = rd_ack_o[port];
      cycles++;
      if (!acked && cycles >= 100) begin
        $display("port %0d was never acked within 100 cycles", port);
        abort_run();
      end
    end
    next_cycle();
    rd_req_i[port] = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // sequences
  //////////////////////////////////////////////////

  initial begin : p_stimulus
    logic [31:0] r;
    int          hold [NumPorts];
    rst_ni    = 1'b0;
    rd_req_i  = '0;
    rd_prio_i = '0;
    rd_addr_i = '0;
    cl_vld_i  = 1'b0;
    cl_i      = '0;
    hold      = '{default: 0};
    model_reset();
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // empty cache misses
    read_word(0, 1'b0, 20'h00005, 6'd3, 5'd0);
    read_word(1, 1'b0, 20'h00005, 6'd3, 5'd8);

    // every word of a fresh line
    write_line(4'b0010, 1'b1, 20'h01234, 6'd7, random_line());
    for (int k = 0; k < WORDS_PER_LINE; k++) begin
      read_word(k % NumPorts, 1'b0, 20'h01234, 6'd7, OFF_WIDTH'(k * 8 + k));
    end

    // three ways of one set, then an absent tag
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (w != 1) begin
        write_line(way_vec_t'(1 << w), 1'b1, TAG_WIDTH'(32'h000a0 + w), 6'd9, random_line());
      end
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      read_word(w % NumPorts, 1'b0, TAG_WIDTH'(32'h000a0 + w), 6'd9, OFF_WIDTH'(w * 8));
    end
    read_word(0, 1'b0, 20'h000ff, 6'd9, 5'd0);

    // invalidate way 2 while port 0 already asks for it
    rd_req_i[0]  = 1'b1;
    rd_addr_i[0] = '{tag: 20'h000a2, idx: 6'd9, off: 5'd16};
    write_line(4'b0100, 1'b0, 20'h000a2, 6'd9, '0);
    read_word(0, 1'b0, 20'h000a2, 6'd9, 5'd16);

    // round-robin, then port 1 at high priority
    rd_addr_i[0] = '{tag: 20'h01234, idx: 6'd7, off: 5'd0};
    rd_addr_i[1] = '{tag: 20'h01234, idx: 6'd7, off: 5'd24};
    rd_req_i     = '1;
    repeat (6) next_cycle();
    rd_prio_i = 2'b10;
    repeat (4) next_cycle();
    rd_req_i  = '0;
    rd_prio_i = '0;
    next_cycle();

    // random traffic, a port keeps its request until acked
    for (int c = 0; c < 2000; c++) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (!rd_req_i[p] || ack_seen[p]) begin
          r            = next_rand();
          hold[p]      = 0;
          rd_req_i[p]  = r[0] | r[1];
          rd_prio_i[p] = r[2] & r[3];
          rd_addr_i[p] = '{tag: TAG_WIDTH'(r[6:4]), idx: IDX_WIDTH'(r[8:7]), off: r[13:9]};
        end else begin
          hold[p]++;
          if (hold[p] >= 100) begin
            $display("port %0d was never acked within 100 cycles", p);
            abort_run();
          end
        end
      end
      r        = next_rand();
      cl_vld_i = (r[2:0] == 3'd0);
      cl_i     = random_line_write();
      next_cycle();
    end
    rd_req_i = '0;
    cl_vld_i = 1'b0;
    next_cycle();
    $display("No errors");
    $finish;
  end

endmodule

//--- hw/dcache_mem_top.sv
`timescale 1ns/1ps
// L1 data cache memory block
// read port arbitration, tag and data arrays with line writes,
// and the hit stage that returns one word per granted read
module dcache_mem_top
  import l1_mem_pkg::*;
#(
  parameter int unsigned NumPorts = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // read ports
  input  logic    [NumPorts-1:0] rd_req_i,
  input  logic    [NumPorts-1:0] rd_prio_i,
  input  rd_req_t [NumPorts-1:0] rd_addr_i,
  output logic    [NumPorts-1:0] rd_ack_o,

  // full line write, takes priority over reads
  input  logic                   cl_vld_i,
  input  cl_wr_t                 cl_i,

  // read result, one cycle after the ack
  output rd_rsp_t                rd_rsp_o
);

  logic                            gnt_vld;
  rd_req_t                         gnt_req;
  tag_entry_t [NUM_WAYS-1:0]       tag_rd;
  bank_row_t  [WORDS_PER_LINE-1:0] row_rd;

  read_arbiter #(
    .NumPorts (NumPorts)
  ) i_read_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (rd_req_i),
    .prio_i    (rd_prio_i),
    .addr_i    (rd_addr_i),
    .block_i   (cl_vld_i),
    .ack_o     (rd_ack_o),
    .gnt_vld_o (gnt_vld),
    .gnt_req_o (gnt_req)
  );

  cache_arrays i_cache_arrays (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cl_vld_i (cl_vld_i),
    .cl_i     (cl_i),
    .rd_vld_i (gnt_vld),
    .rd_req_i (gnt_req),
    .tag_o    (tag_rd),
    .row_o    (row_rd)
  );

  hit_select i_hit_select (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .rd_vld_i (gnt_vld),
    .rd_req_i (gnt_req),
    .tag_i    (tag_rd),
    .row_i    (row_rd),
    .rsp_o    (rd_rsp_o)
  );

endmodule

//--- hw/hit_select.sv
`timescale 1ns/1ps
// Lookup and hit stage
// keeps the context of the granted read for one cycle, compares the
// tags of all ways and picks the word of the hitting way
module hit_select
  import l1_mem_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            rd_vld_i,
  input  rd_req_t                         rd_req_i,
  input  tag_entry_t [NUM_WAYS-1:0]       tag_i,
  input  bank_row_t  [WORDS_PER_LINE-1:0] row_i,
  output rd_rsp_t                         rsp_o
);

  logic                      vld_q;
  logic [TAG_WIDTH-1:0]      tag_q;
  logic [WORD_SEL_WIDTH-1:0] word_q;
  way_vec_t                  hit_way;
  way_vec_t                  vld_bits;
  bank_row_t                 row;
  logic [WORD_WIDTH-1:0]     data;

  //////////////////////////////////////////////////
  // lookup context
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= rd_vld_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_vld_i) begin
      tag_q  <= rd_req_i.tag;
      word_q <= word_sel(rd_req_i.off);
    end
  end

  //////////////////////////////////////////////////
  // compare and select
  //////////////////////////////////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign vld_bits[w] = vld_q & tag_i[w].valid;
    assign hit_way[w]  = vld_bits[w] & (tag_i[w].tag == tag_q);
  end

  assign row = row_i[word_q];

  // lowest hitting way wins, a miss leaves zero
  always_comb begin : p_word
    data = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_way[w]) begin
        data = row[w];
      end
    end
  end

  assign rsp_o = '{
    valid:    vld_q,
    hit:      |hit_way,
    hit_way:  hit_way,
    vld_bits: vld_bits,
    data:     data
  };

endmodule

//--- hw/cache_arrays.sv
`timescale 1ns/1ps
// Cache memory arrays
// one tag RAM per way, one data RAM per word offset holding that word
// for all ways, and reset-cleared valid bits kept next to the tag RAMs
module cache_arrays
  import l1_mem_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                cl_vld_i,
  input  cl_wr_t                              cl_i,
  input  logic                                rd_vld_i,
  input  rd_req_t                             rd_req_i,
  output tag_entry_t [NUM_WAYS-1:0]           tag_o,
  output bank_row_t  [WORDS_PER_LINE-1:0]     row_o
);

  logic [IDX_WIDTH-1:0]                  addr;
  logic [WORD_SEL_WIDTH-1:0]             rd_word;
  tag_entry_t                            tag_wdata;
  tag_entry_t [NUM_WAYS-1:0]             tag_rdata;
  logic       [NUM_WAYS-1:0]             tag_req;
  logic       [WORDS_PER_LINE-1:0]       bank_req;
  bank_row_t  [WORDS_PER_LINE-1:0]       bank_wdata;
  bank_row_t                             bank_wmask;
  logic       [NUM_WAYS-1:0][NUM_SETS-1:0] vld_q;
  way_vec_t                              vld_rd_q;

  //////////////////////////////////////////////////
  // write and read steering
  //////////////////////////////////////////////////

  // the line write wins the arrays, reads are not granted meanwhile
  assign addr      = cl_vld_i ? cl_i.idx : rd_req_i.idx;
  assign rd_word   = word_sel(rd_req_i.off);
  assign tag_wdata = '{valid: cl_i.valid, tag: cl_i.tag};

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way_ctrl
    assign tag_req[w]    = cl_vld_i ? cl_i.way_en[w] : rd_vld_i;
    // each way owns a slice of every bank row
    assign bank_wmask[w] = {WORD_WIDTH{cl_i.way_en[w]}};
  end

  for (genvar k = 0; k < WORDS_PER_LINE; k++) begin : gen_bank_ctrl
    // reads only wake the bank of the requested word
    assign bank_req[k]   = cl_vld_i | (rd_vld_i & (rd_word == WORD_SEL_WIDTH'(k)));
    assign bank_wdata[k] = {NUM_WAYS{cl_i.data[k]}};
  end

  //////////////////////////////////////////////////
  // valid bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q    <= '0;
      vld_rd_q <= '0;
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (cl_vld_i && cl_i.way_en[w]) begin
          vld_q[w][cl_i.idx] <= cl_i.valid;
        end
        if (rd_vld_i) begin
          vld_rd_q[w] <= vld_q[w][rd_req_i.idx];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // RAMs
  //////////////////////////////////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_tag_ram
    cache_sram #(
      .word_t (tag_entry_t),
      .Depth  (NUM_SETS)
    ) i_tag_ram (
      .clk_i   (clk_i),
      .req_i   (tag_req[w]),
      .we_i    (cl_vld_i),
      .addr_i  (addr),
      .wdata_i (tag_wdata),
      .wmask_i ('1),
      .rdata_o (tag_rdata[w])
    );

    // the RAM copy of valid is undefined after reset
    assign tag_o[w] = '{valid: vld_rd_q[w], tag: tag_rdata[w].tag};
  end

  for (genvar k = 0; k < WORDS_PER_LINE; k++) begin : gen_data_ram
    cache_sram #(
      .word_t (bank_row_t),
      .Depth  (NUM_SETS)
    ) i_data_ram (
      .clk_i   (clk_i),
      .req_i   (bank_req[k]),
      .we_i    (cl_vld_i),
      .addr_i  (addr),
      .wdata_i (bank_wdata[k]),
      .wmask_i (bank_wmask),
      .rdata_o (row_o[k])
    );
  end

endmodule

//--- hw/read_arbiter.sv
`timescale 1ns/1ps
// Read port arbiter
// high priority requests mask low priority ones, a round-robin
// pointer picks among the rest; nothing is granted during a line write
module read_arbiter
  import l1_mem_pkg::*;
#(
  parameter int unsigned NumPorts = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic    [NumPorts-1:0] req_i,
  input  logic    [NumPorts-1:0] prio_i,
  input  rd_req_t [NumPorts-1:0] addr_i,
  input  logic                   block_i,
  output logic    [NumPorts-1:0] ack_o,
  output logic                   gnt_vld_o,
  output rd_req_t                gnt_req_o
);

  localparam int unsigned IdxWidth = $clog2(NumPorts);

  logic [NumPorts-1:0] req_prio;
  logic [NumPorts-1:0] req_masked;
  logic [IdxWidth-1:0] ptr_d, ptr_q;
  logic [IdxWidth-1:0] gnt_idx;
  logic                found;

  //////////////////////////////////////////////////
  // priority masking
  //////////////////////////////////////////////////

  assign req_prio   = req_i & prio_i;
  assign req_masked = (|req_prio) ? req_prio : req_i;

  //////////////////////////////////////////////////
  // round-robin search
  //////////////////////////////////////////////////

  // first eligible port at or after the pointer, with wraparound
  always_comb begin : p_search
    int unsigned cand;
    found   = 1'b0;
    gnt_idx = '0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      cand = (int'(ptr_q) + i) % NumPorts;
      if (!found && req_masked[cand]) begin
        found   = 1'b1;
        gnt_idx = cand[IdxWidth-1:0];
      end
    end
  end

  assign gnt_vld_o = found & ~block_i;

  always_comb begin : p_ack
    ack_o = '0;
    if (gnt_vld_o) begin
      ack_o[gnt_idx] = 1'b1;
    end
  end

  // winning address goes to the arrays even when not valid
  assign gnt_req_o = addr_i[gnt_idx];

  //////////////////////////////////////////////////
  // pointer
  //////////////////////////////////////////////////

  always_comb begin : p_ptr
    ptr_d = ptr_q;
    if (gnt_vld_o) begin
      if (gnt_idx == IdxWidth'(NumPorts - 1)) begin
        ptr_d = '0;
      end else begin
        ptr_d = gnt_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

endmodule

//--- hw/cache_sram.sv
`timescale 1ns/1ps
// Single-port synchronous RAM
// registered read with one cycle of latency, bitwise write mask,
// generic over the stored word type
module cache_sram #(
  parameter type         word_t = logic [63:0],
  parameter int unsigned Depth  = 64
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  word_t                    wdata_i,
  input  word_t                    wmask_i,
  output word_t                    rdata_o
);

  localparam int unsigned Width = $bits(word_t);

  logic [Width-1:0] mem_q [Depth];
  logic [Width-1:0] rdata_q;
  logic [Width-1:0] wdata;
  logic [Width-1:0] wmask;

  assign wdata = wdata_i;
  assign wmask = wmask_i;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // only masked bits change, the rest of the entry is kept
        for (int b = 0; b < Width; b++) begin
          if (wmask[b]) begin
            mem_q[addr_i][b] <= wdata[b];
          end
        end
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = word_t'(rdata_q);

endmodule

//--- hw/l1_mem_pkg.sv
// L1 data cache memory package
// cache geometry, address fields and the structs shared by the
// arbiter, the arrays, the hit stage and the top level
package l1_mem_pkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////

  localparam int unsigned NUM_WAYS       = 4;
  localparam int unsigned NUM_SETS       = 64;
  localparam int unsigned WORDS_PER_LINE = 4;
  localparam int unsigned WORD_WIDTH     = 64;

  localparam int unsigned IDX_WIDTH      = $clog2(NUM_SETS);
  localparam int unsigned WORD_SEL_WIDTH = $clog2(WORDS_PER_LINE);
  localparam int unsigned BYTE_OFF_WIDTH = $clog2(WORD_WIDTH / 8);
  localparam int unsigned OFF_WIDTH      = WORD_SEL_WIDTH + BYTE_OFF_WIDTH;
  localparam int unsigned TAG_WIDTH      = 20;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic [NUM_WAYS-1:0] way_vec_t;

  typedef struct packed {
    logic                 valid;
    logic [TAG_WIDTH-1:0] tag;
  } tag_entry_t;

  // one data bank row holds the same word offset of every way
  typedef logic [NUM_WAYS-1:0][WORD_WIDTH-1:0]       bank_row_t;
  typedef logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] line_t;

  typedef struct packed {
    logic [TAG_WIDTH-1:0] tag;
    logic [IDX_WIDTH-1:0] idx;
    logic [OFF_WIDTH-1:0] off;
  } rd_req_t;

  typedef struct packed {
    way_vec_t             way_en;
    logic                 valid;
    logic [TAG_WIDTH-1:0] tag;
    logic [IDX_WIDTH-1:0] idx;
    line_t                data;
  } cl_wr_t;

  typedef struct packed {
    logic                  valid;
    logic                  hit;
    way_vec_t              hit_way;
    way_vec_t              vld_bits;
    logic [WORD_WIDTH-1:0] data;
  } rd_rsp_t;

  // word offset inside the line, drops the byte bits
  function automatic logic [WORD_SEL_WIDTH-1:0] word_sel(logic [OFF_WIDTH-1:0] off);
    return off[OFF_WIDTH-1:BYTE_OFF_WIDTH];
  endfunction

endpackage
